// ==== src/cpu_consts.svh ====
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// Word-address bits of the data RAM
`define RAM_ADDR_BITS 8

// Number of 32-bit words
`define RAM_DEPTH (1 << `RAM_ADDR_BITS)

// Lowest byte-address bit that selects a word
`define RAM_WORD_LSB 2

`endif

// ==== src/cpu_pkg.sv ====
package cpu_pkg;

  // Bus widths
  parameter int RegBusWidth   = 32;
  parameter int DataWidth     = 32;
  parameter int Func3BusWidth = 3;

  // Strobe levels
  parameter logic ReadEnable   = 1'b1;
  parameter logic ReadDisable  = 1'b0;
  parameter logic WriteEnable  = 1'b1;
  parameter logic WriteDisable = 1'b0;

  parameter logic [RegBusWidth-1:0] ZeroWord = 32'h0000_0000;

  // Store funct3 codes
  typedef enum logic [Func3BusWidth-1:0] {
    OP_SB = 3'b000,
    OP_SH = 3'b001,
    OP_SW = 3'b010
  } store_op_e;

  // Load funct3 codes, bit 2 marks the unsigned forms
  typedef enum logic [Func3BusWidth-1:0] {
    OP_LB  = 3'b000,
    OP_LH  = 3'b001,
    OP_LW  = 3'b010,
    OP_LBU = 3'b100,
    OP_LHU = 3'b101
  } load_op_e;

  // Request from the memory stage to the data RAM
  typedef struct packed {
    logic                   rd;     // Read strobe
    logic                   wr;     // Write strobe
    logic [DataWidth/8-1:0] be;     // Lane i covers wdata[8i+7:8i]
    logic [RegBusWidth-1:0] addr;   // Byte address
    logic [DataWidth-1:0]   wdata;  // Already shifted onto its lanes
  } mem_req_t;

  // Load context, carried alongside the RAM read
  typedef struct packed {
    logic [Func3BusWidth-1:0] func3;
    logic [1:0]               offset;  // Byte offset within the word
  } load_tag_t;

endpackage

// ==== src/mem.sv ====
`timescale 1ns/10ps

module mem
  import cpu_pkg::*;
(
  input  logic                     memrd_i,
  input  logic                     memwr_i,
  input  logic [  RegBusWidth-1:0] wreg_data_i,  // Computed address
  input  logic [  RegBusWidth-1:0] wdata_i,
  input  logic [Func3BusWidth-1:0] func3_i,

  output mem_req_t                 req_o,
  output load_tag_t                tag_o
);

  logic [RegBusWidth-1:0] memaddr;

  assign memaddr = wreg_data_i;

  always_comb begin
    // Idle request is all zeros
    req_o.rd    = ReadDisable;
    req_o.wr    = WriteDisable;
    req_o.be    = {WriteDisable, WriteDisable, WriteDisable, WriteDisable};
    req_o.addr  = ZeroWord;
    req_o.wdata = ZeroWord;
    tag_o       = '0;

    if (memrd_i == ReadEnable && memwr_i == WriteDisable) begin  // Load
      req_o.rd     = ReadEnable;
      req_o.addr   = memaddr;
      tag_o.func3  = func3_i;
      tag_o.offset = memaddr[1:0];
    end else if (memrd_i == ReadDisable && memwr_i == WriteEnable) begin  // Store
      req_o.wr   = WriteEnable;
      req_o.addr = memaddr;
      case (func3_i)
        OP_SW: begin
          req_o.be    = {WriteEnable, WriteEnable, WriteEnable, WriteEnable};
          req_o.wdata = wdata_i;
        end
        OP_SH: begin
          // Address bit 0 is ignored for halfwords
          if (memaddr[1]) begin
            req_o.be    = {WriteEnable, WriteEnable, WriteDisable, WriteDisable};
            req_o.wdata = {wdata_i[15:0], 16'b0};
          end else begin
            req_o.be    = {WriteDisable, WriteDisable, WriteEnable, WriteEnable};
            req_o.wdata = {16'b0, wdata_i[15:0]};
          end
        end
        OP_SB: begin
          case (memaddr[1:0])
            2'b00: begin
              req_o.be    = {WriteDisable, WriteDisable, WriteDisable, WriteEnable};
              req_o.wdata = {24'b0, wdata_i[7:0]};
            end
            2'b01: begin
              req_o.be    = {WriteDisable, WriteDisable, WriteEnable, WriteDisable};
              req_o.wdata = {16'b0, wdata_i[7:0], 8'b0};
            end
            2'b10: begin
              req_o.be    = {WriteDisable, WriteEnable, WriteDisable, WriteDisable};
              req_o.wdata = {8'b0, wdata_i[7:0], 16'b0};
            end
            default: begin
              req_o.be    = {WriteEnable, WriteDisable, WriteDisable, WriteDisable};
              req_o.wdata = {wdata_i[7:0], 24'b0};
            end
          endcase
        end
        default: begin
          // Unknown funct3 writes nothing
          req_o.be    = {WriteDisable, WriteDisable, WriteDisable, WriteDisable};
          req_o.wdata = wdata_i;
        end
      endcase
    end
  end

endmodule

// ==== src/data_ram.sv ====
`timescale 1ns/10ps
`include "cpu_consts.svh"

module data_ram
  import cpu_pkg::*;
(
  input  logic                 clk_i,
  input  mem_req_t             req_i,
  output logic [DataWidth-1:0] rdata_o
);

  logic [DataWidth-1:0]      ram_q [`RAM_DEPTH];
  logic [`RAM_ADDR_BITS-1:0] word_idx;

  // Word index from the byte address, upper bits wrap
  assign word_idx = req_i.addr[`RAM_WORD_LSB +: `RAM_ADDR_BITS];

  // Byte-lane writes
  always_ff @(posedge clk_i) begin
    if (req_i.wr) begin
      for (int lane = 0; lane < DataWidth / 8; lane++) begin
        if (req_i.be[lane]) begin
          ram_q[word_idx][lane*8 +: 8] <= req_i.wdata[lane*8 +: 8];
        end
      end
    end
  end

  // Registered read, holds between reads
  always_ff @(posedge clk_i) begin
    if (req_i.rd) begin
      rdata_o <= ram_q[word_idx];
    end
  end

endmodule

// ==== src/load_align.sv ====
`timescale 1ns/10ps

module load_align
  import cpu_pkg::*;
(
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  logic                   rd_i,
  input  load_tag_t              tag_i,
  input  logic [DataWidth-1:0]   rdata_i,
  output logic [RegBusWidth-1:0] load_data_o,
  output logic                   load_valid_o
);

  load_tag_t   tag_q;
  logic        valid_q;
  logic [7:0]  byte_sel;
  logic [15:0] half_sel;

  // Valid follows the read strobe by one cycle
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= rd_i;
    end
  end

  // Captured on the same edge the RAM samples the read
  always_ff @(posedge clk_i) begin
    if (rd_i) begin
      tag_q <= tag_i;
    end
  end

  assign byte_sel = rdata_i[{tag_q.offset, 3'b000} +: 8];
  assign half_sel = rdata_i[{tag_q.offset[1], 4'b0000} +: 16];  // Offset bit 0 ignored

  always_comb begin
    case (tag_q.func3)
      OP_LB: begin
        load_data_o = {{(RegBusWidth - 8){byte_sel[7]}}, byte_sel};
      end
      OP_LBU: begin
        load_data_o = {{(RegBusWidth - 8){1'b0}}, byte_sel};
      end
      OP_LH: begin
        load_data_o = {{(RegBusWidth - 16){half_sel[15]}}, half_sel};
      end
      OP_LHU: begin
        load_data_o = {{(RegBusWidth - 16){1'b0}}, half_sel};
      end
      OP_LW: begin
        load_data_o = rdata_i;
      end
      default: begin
        load_data_o = rdata_i;  // Raw word for undefined funct3
      end
    endcase
  end

  assign load_valid_o = valid_q;

endmodule

// ==== src/mem_access_top.sv ====
`timescale 1ns/10ps

module mem_access_top
  import cpu_pkg::*;
(
  input  logic                     clk_i,
  input  logic                     rst_i,
  input  logic                     memrd_i,
  input  logic                     memwr_i,
  input  logic [  RegBusWidth-1:0] wreg_data_i,
  input  logic [  RegBusWidth-1:0] wdata_i,
  input  logic [Func3BusWidth-1:0] func3_i,
  output mem_req_t                 mem_req_o,
  output logic [  RegBusWidth-1:0] load_data_o,
  output logic                     load_valid_o
);

  mem_req_t               req;
  load_tag_t              tag;
  logic [DataWidth-1:0]   rdata;

  mem u_mem (
    .memrd_i    (memrd_i),
    .memwr_i    (memwr_i),
    .wreg_data_i(wreg_data_i),
    .wdata_i    (wdata_i),
    .func3_i    (func3_i),
    .req_o      (req),
    .tag_o      (tag)
  );

  data_ram u_data_ram (
    .clk_i  (clk_i),
    .req_i  (req),
    .rdata_o(rdata)
  );

  load_align u_load_align (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .rd_i        (req.rd),
    .tag_i       (tag),
    .rdata_i     (rdata),
    .load_data_o (load_data_o),
    .load_valid_o(load_valid_o)
  );

  assign mem_req_o = req;  // Exported for observation

endmodule

// ==== tests/mem_access_properties.sv ====
`timescale 1ns/10ps

module mem_access_properties
  import cpu_pkg::*;
(
  input logic     clk_i,
  input logic     rst_i,
  input mem_req_t req_i,
  input logic     load_valid_i
);

  // Lane enables only come with a write
  be_needs_wr: assert property (@(posedge clk_i) disable iff (rst_i)
    !req_i.wr |-> req_i.be == '0)
    else $error("byte enables set while the write strobe is low");

  strobes_exclusive: assert property (@(posedge clk_i) disable iff (rst_i)
    !(req_i.rd && req_i.wr))
    else $error("read and write strobes high in the same cycle");

  valid_after_rd: assert property (@(posedge clk_i) disable iff (rst_i)
    req_i.rd |=> load_valid_i)
    else $error("no load valid one cycle after a read request");

  // A valid pulse always has a read behind it
  valid_has_rd: assert property (@(posedge clk_i) disable iff (rst_i)
    load_valid_i |-> $past(req_i.rd))
    else $error("load valid without a read request in the cycle before");

  valid_low_in_reset: assert property (@(posedge clk_i)
    rst_i |=> !load_valid_i)
    else $error("load valid high while reset is applied");

endmodule

bind mem_access_top mem_access_properties u_props (
  .clk_i       (clk_i),
  .rst_i       (rst_i),
  .req_i       (mem_req_o),
  .load_valid_i(load_valid_o)
);

// ==== tests/tb_mem_access.sv ====
`timescale 1ns/10ps
`include "cpu_consts.svh"

module tb_mem_access
  import cpu_pkg::*;
();

  localparam int ClkPeriod    = 20;
  localparam int DriveDelay   = 2;
  localparam int ResetCycles  = 5;
  localparam int Seed         = 62;
  localparam int ShadowBits   = `RAM_ADDR_BITS + `RAM_WORD_LSB;
  localparam int ShadowBytes  = 1 << ShadowBits;
  localparam int NumWords     = 32;
  localparam int NumStream    = 200;
  localparam int NumTests     = 6;
  localparam int TotalOps     = `RAM_DEPTH + 2 * NumWords + 12 + 34 + 9 + NumStream + NumTests;
  localparam int MarginCycles = 50;
  localparam int TimeoutCycles = ResetCycles + TotalOps + MarginCycles;

  typedef struct packed {
    logic [RegBusWidth-1:0]   addr;
    logic [Func3BusWidth-1:0] func3;
    logic [RegBusWidth-1:0]   expected;
    logic [31:0]              cycle;     // Cycle in which the load was driven
  } pending_t;

  logic                     clk_i;
  logic                     rst_i;
  logic                     memrd_i;
  logic                     memwr_i;
  logic [RegBusWidth-1:0]   wreg_data_i;
  logic [RegBusWidth-1:0]   wdata_i;
  logic [Func3BusWidth-1:0] func3_i;
  mem_req_t                 mem_req_o;
  logic [RegBusWidth-1:0]   load_data_o;
  logic                     load_valid_o;

  logic [7:0]  shadow [ShadowBytes];  // Byte-addressed model of the RAM
  pending_t    pend_q [$];
  logic [31:0] cycle_cnt = '0;
  int          op_checks = 0;
  int          op_errors = 0;
  int          load_checks = 0;
  int          load_errors = 0;
  int          tests = 0;
  int          errors_at_start = 0;

  mem_access_top dut (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .memrd_i     (memrd_i),
    .memwr_i     (memwr_i),
    .wreg_data_i (wreg_data_i),
    .wdata_i     (wdata_i),
    .func3_i     (func3_i),
    .mem_req_o   (mem_req_o),
    .load_data_o (load_data_o),
    .load_valid_o(load_valid_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #(ClkPeriod / 2) clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
  end

  function automatic logic [7:0] byte_at(logic [RegBusWidth-1:0] addr);
    return shadow[addr[ShadowBits-1:0]];  // Upper address bits wrap
  endfunction

  function automatic void write_shadow(logic [RegBusWidth-1:0] addr, logic [7:0] value);
    shadow[addr[ShadowBits-1:0]] = value;
  endfunction

  function automatic void store_shadow(logic [RegBusWidth-1:0] addr,
                                       logic [RegBusWidth-1:0] data,
                                       logic [Func3BusWidth-1:0] func3);
    case (func3)
      OP_SB: begin
        write_shadow(addr, data[7:0]);
      end
      OP_SH: begin
        write_shadow({addr[RegBusWidth-1:1], 1'b0}, data[7:0]);
        write_shadow({addr[RegBusWidth-1:1], 1'b1}, data[15:8]);
      end
      OP_SW: begin
        for (int k = 0; k < 4; k++) begin
          write_shadow({addr[RegBusWidth-1:2], 2'(k)}, data[k*8 +: 8]);
        end
      end
      default: begin
      end
    endcase
  endfunction

  function automatic logic [RegBusWidth-1:0] expected_load(logic [RegBusWidth-1:0] addr,
                                                           logic [Func3BusWidth-1:0] func3);
    logic [7:0]             b;
    logic [15:0]            h;
    logic [RegBusWidth-1:0] w;
    b = byte_at(addr);
    h = {byte_at({addr[RegBusWidth-1:1], 1'b1}), byte_at({addr[RegBusWidth-1:1], 1'b0})};
    w = {byte_at({addr[RegBusWidth-1:2], 2'b11}), byte_at({addr[RegBusWidth-1:2], 2'b10}),
         byte_at({addr[RegBusWidth-1:2], 2'b01}), byte_at({addr[RegBusWidth-1:2], 2'b00})};
    case (func3)
      OP_LB:   return {{24{b[7]}}, b};
      OP_LBU:  return {24'b0, b};
      OP_LH:   return {{16{h[15]}}, h};
      OP_LHU:  return {16'b0, h};
      default: return w;  // LW and undefined codes give the whole word
    endcase
  endfunction

  function automatic mem_req_t expected_request(logic rd, logic wr,
                                                logic [RegBusWidth-1:0] addr,
                                                logic [RegBusWidth-1:0] data,
                                                logic [Func3BusWidth-1:0] func3);
    mem_req_t req;
    req = '0;
    if (rd && !wr) begin
      req.rd   = 1'b1;
      req.addr = addr;
    end else if (wr && !rd) begin
      req.wr    = 1'b1;
      req.addr  = addr;
      req.wdata = data;
      case (func3)
        OP_SB: begin
          req.be    = 4'b0001 << addr[1:0];
          req.wdata = {24'b0, data[7:0]} << (8 * addr[1:0]);
        end
        OP_SH: begin
          req.be    = addr[1] ? 4'b1100 : 4'b0011;
          req.wdata = {16'b0, data[15:0]} << (16 * addr[1]);
        end
        OP_SW: req.be = 4'b1111;
        default: req.be = 4'b0000;
      endcase
    end
    return req;
  endfunction

  function automatic logic [RegBusWidth-1:0] fill_word(int i);
    logic [7:0] idx;
    idx = i[7:0];
    return {idx ^ 8'hA7, ~idx, idx + 8'h3D, idx};
  endfunction

  function automatic logic [Func3BusWidth-1:0] pick_load_op(logic [2:0] sel);
    case (sel)
      3'd0:    return OP_LB;
      3'd1:    return OP_LH;
      3'd3:    return OP_LBU;
      3'd4:    return OP_LHU;
      default: return OP_LW;
    endcase
  endfunction

  function automatic logic [Func3BusWidth-1:0] pick_store_op(logic [1:0] sel);
    case (sel)
      2'd0:    return OP_SB;
      2'd1:    return OP_SH;
      2'd2:    return OP_SW;
      default: return 3'b011;  // Not a store code so nothing is written
    endcase
  endfunction

  // One request per cycle starting just after a rising edge
  task automatic issue(input logic rd, input logic wr, input logic [RegBusWidth-1:0] addr,
                       input logic [RegBusWidth-1:0] data,
                       input logic [Func3BusWidth-1:0] func3);
    mem_req_t exp_req;
    pending_t entry;
    memrd_i     = rd;
    memwr_i     = wr;
    wreg_data_i = addr;
    wdata_i     = data;
    func3_i     = func3;
    exp_req     = expected_request(rd, wr, addr, data, func3);
    if (rd && !wr) begin
      entry.addr     = addr;
      entry.func3    = func3;
      entry.expected = expected_load(addr, func3);
      entry.cycle    = cycle_cnt;
      pend_q.push_back(entry);
    end else if (wr && !rd) begin
      store_shadow(addr, data, func3);
    end
    @(negedge clk_i);
    op_checks++;
    assert (mem_req_o === exp_req) else begin
      op_errors++;
      $display("mismatch at %0t: request for addr %h func3 %b is %h, expected %h",
               $time, addr, func3, mem_req_o, exp_req);
    end
    @(posedge clk_i);
    #DriveDelay;
  endtask

  task automatic store(input logic [RegBusWidth-1:0] addr, input logic [RegBusWidth-1:0] data,
                       input logic [Func3BusWidth-1:0] func3);
    issue(1'b0, 1'b1, addr, data, func3);
  endtask

  task automatic load(input logic [RegBusWidth-1:0] addr,
                      input logic [Func3BusWidth-1:0] func3);
    issue(1'b1, 1'b0, addr, $urandom, func3);
  endtask

  task automatic start_test();
    errors_at_start = op_errors + load_errors;
  endtask

  // Idle cycle lets the last load result come back
  task automatic finish_test(input string name);
    int errs;
    issue(1'b0, 1'b0, ZeroWord, ZeroWord, 3'b000);
    op_checks++;
    assert (pend_q.size() == 0) else begin
      op_errors++;
      $display("test %s ended with %0d loads still waiting for a result", name, pend_q.size());
    end
    errs = op_errors + load_errors - errors_at_start;
    tests++;
    $display("test %-18s done, %0d errors", name, errs);
  endtask

  always @(negedge clk_i) begin
    pending_t entry;
    if (!rst_i && load_valid_o) begin
      load_checks++;
      assert (pend_q.size() > 0) else begin
        load_errors++;
        $display("load valid pulse at %0t without any load pending", $time);
      end
      if (pend_q.size() > 0) begin
        entry = pend_q.pop_front();
        assert (load_data_o === entry.expected) else begin
          load_errors++;
          $display("mismatch at %0t: load addr %h func3 %b returned %h, expected %h",
                   $time, entry.addr, entry.func3, load_data_o, entry.expected);
        end
        assert (cycle_cnt == entry.cycle + 1) else begin
          load_errors++;
          $display("load result for addr %h at %0t came %0d cycles after its request",
                   entry.addr, $time, cycle_cnt - entry.cycle);
        end
      end
    end
  end

  initial begin
    #(TimeoutCycles * ClkPeriod);
    $display("timeout: run did not finish within %0d cycles", TimeoutCycles);
    $display(">>> FAIL");
    $finish;
  end

  initial begin
    logic [RegBusWidth-1:0] rnd;
    logic [RegBusWidth-1:0] word;
    logic [RegBusWidth-1:0] addr_q [$];
    void'($urandom(Seed));
    rst_i       = 1'b1;
    memrd_i     = 1'b1;  // Read requested during reset must not raise valid
    memwr_i     = 1'b0;
    wreg_data_i = ZeroWord;
    wdata_i     = ZeroWord;
    func3_i     = 3'b000;
    repeat (ResetCycles - 1) @(posedge clk_i);
    #DriveDelay;
    memrd_i = 1'b0;
    @(posedge clk_i);
    #DriveDelay;
    rst_i = 1'b0;

    // RAM is not reset so every word gets a known value first
    start_test();
    for (int i = 0; i < `RAM_DEPTH; i++) begin
      store(i * 4, fill_word(i), OP_SW);
    end
    finish_test("preload");

    start_test();
    for (int i = 0; i < NumWords; i++) begin
      rnd = $urandom;
      addr_q.push_back({rnd[RegBusWidth-1:2], 2'b00});
      store(addr_q[$], $urandom, OP_SW);
    end
    while (addr_q.size() > 0) begin
      load(addr_q.pop_front(), OP_LW);
    end
    finish_test("word_round_trip");

    start_test();
    rnd  = $urandom;
    word = {rnd[RegBusWidth-1:2], 2'b00};
    for (int k = 0; k < 4; k++) begin
      store({word[RegBusWidth-1:2], 2'(k)}, $urandom, OP_SB);
      load(word, OP_LW);
    end
    for (int k = 0; k < 2; k++) begin
      rnd = $urandom;
      store({word[RegBusWidth-1:2], 1'(k), rnd[0]}, rnd, OP_SH);  // Bit 0 is don't care
      load(word, OP_LW);
    end
    finish_test("store_lanes");

    start_test();
    for (int p = 0; p < 2; p++) begin
      rnd  = $urandom;
      word = {rnd[RegBusWidth-1:2], 2'b00};
      store(word, (p == 0) ? 32'h807F_7F80 : 32'h7FFF_FF7F, OP_SW);
      for (int k = 0; k < 4; k++) begin
        load({word[RegBusWidth-1:2], 2'(k)}, OP_LB);
        load({word[RegBusWidth-1:2], 2'(k)}, OP_LBU);
        load({word[RegBusWidth-1:2], 2'(k)}, OP_LH);
        load({word[RegBusWidth-1:2], 2'(k)}, OP_LHU);
      end
    end
    finish_test("load_extension");

    start_test();
    for (int k = 0; k < 3; k++) begin
      rnd = $urandom;
      issue(1'b1, 1'b1, rnd, $urandom, OP_SW);
      issue(1'b0, 1'b0, rnd, $urandom, OP_SW);
      load(rnd, OP_LW);  // Word must be unchanged
    end
    finish_test("idle_strobes");

    // Small address window so loads often hit recent stores
    start_test();
    for (int i = 0; i < NumStream; i++) begin
      rnd = $urandom;
      if (rnd[31]) begin
        load($urandom_range(63, 0), pick_load_op(rnd[2:0]));
      end else begin
        store($urandom_range(63, 0), $urandom, pick_store_op(rnd[1:0]));
      end
    end
    finish_test("back_to_back");

    $display("tests %0d, checks %0d, errors %0d", tests, op_checks + load_checks,
             op_errors + load_errors);
    if (op_errors + load_errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

// ==== flist.f ====
+incdir+src
src/cpu_pkg.sv
src/mem.sv
src/data_ram.sv
src/load_align.sv
src/mem_access_top.sv
tests/mem_access_properties.sv
tests/tb_mem_access.sv

// ==== Makefile ====
TOOL   := verilator
FLAGS  := --binary --timing --assert -j 0
TOP    := tb_mem_access
FLIST  := flist.f
OBJDIR := obj_dir
LOG    := sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f $(FLIST)
	-./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q ">>> FAIL" $(LOG); then \
	  echo "simulation reported failure"; \
	  exit 1; \
	fi
	@if ! grep -q ">>> PASS" $(LOG); then \
	  echo "simulation ended without a result"; \
	  exit 1; \
	fi

clean:
	rm -rf $(OBJDIR) $(LOG)
